// File: include/coh_defines.svh
`ifndef COH_DEFINES_SVH
`define COH_DEFINES_SVH

// Cache geometry
`define COH_WAYS 4
`define COH_SETS 16

// Address and data widths on both buses
`define COH_ADDR_W 32
`define COH_LINE_W 256

// Node numbering on the coherence buses
`define COH_NODE_W 2

// Memory answers as this node and the caches use the ids below it
`define COH_MEM_NODE 3

`endif

// File: logic/coh_pkg.sv
`include "coh_defines.svh"

package coh_pkg;

  // Byte address as it travels on the CPU side and on both buses
  typedef logic [`COH_ADDR_W-1:0] addr_t;

  // One full cache line of data
  typedef logic [`COH_LINE_W-1:0] line_t;

  // Cache or memory node number
  typedef logic [`COH_NODE_W-1:0] node_id_t;

  // One bit per way as the tag arrays report hits and victims
  typedef logic [`COH_WAYS-1:0] way_vec_t;

  // Number of a single way
  typedef logic [$clog2(`COH_WAYS)-1:0] way_idx_t;

  // Set index taken from the low address bits
  typedef logic [$clog2(`COH_SETS)-1:0] set_idx_t;

  // Stable MESI states plus the transient states of the load path
  // and of the data supply after a snoop
  typedef enum logic [2:0] {
    LS_I,
    LS_ISAD,
    LS_ISD,
    LS_S,
    LS_E,
    LS_SRD,
    LS_IRD
  } line_state_t;

  // Request bus transaction kind
  typedef enum logic [1:0] {
    REQ_NONE,
    REQ_GETS,
    REQ_GETM
  } bus_req_t;

  // Response bus message kind with exclusive granting the line in E
  typedef enum logic {
    RESP_DATA,
    RESP_EXCLUSIVE
  } resp_kind_t;

endpackage

// File: logic/coh_event_decode.sv
`timescale 1ns/1ps

module coh_event_decode #(
  parameter coh_pkg::node_id_t node_id = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_msg_valid,
  input  coh_pkg::bus_req_t    req_msg_kind,
  input  coh_pkg::node_id_t    req_msg_source,
  input  coh_pkg::addr_t       req_msg_addr,
  input  logic                 resp_msg_valid,
  input  coh_pkg::resp_kind_t  resp_msg_kind,
  input  coh_pkg::node_id_t    resp_msg_source,
  input  coh_pkg::way_idx_t    resp_msg_way,
  input  coh_pkg::node_id_t    resp_msg_destination,
  input  coh_pkg::addr_t       resp_msg_addr,
  input  coh_pkg::line_t       resp_msg_data,
  input  coh_pkg::addr_t       dfp_addr,
  input  logic                 dfp_read,
  input  logic                 cache_read_request,
  input  coh_pkg::way_vec_t    cache_hit_vector,
  input  coh_pkg::way_vec_t    evict_candidate,
  input  coh_pkg::way_vec_t    bus_hit_vector,
  input  logic                 invalidate_req,
  input  coh_pkg::line_t       bus_rdata,
  output logic                 ev_req,
  output logic                 ev_resp,
  output logic                 ev_cpu,
  output logic                 ev_own,
  output coh_pkg::set_idx_t    ev_index,
  output coh_pkg::addr_t       ev_addr,
  output coh_pkg::bus_req_t    ev_req_kind,
  output coh_pkg::node_id_t    ev_source,
  output coh_pkg::resp_kind_t  ev_resp_kind,
  output coh_pkg::way_idx_t    ev_resp_way,
  output logic                 ev_to_me,
  output coh_pkg::line_t       ev_data,
  output coh_pkg::way_vec_t    ev_hit,
  output coh_pkg::way_vec_t    ev_victim,
  output coh_pkg::way_vec_t    ev_snoop_hit,
  output logic                 ev_load_miss,
  output logic                 ev_load_hit,
  output logic                 ev_inval,
  output coh_pkg::set_idx_t    ev_inval_index,
  output coh_pkg::way_vec_t    ev_inval_hit,
  output coh_pkg::line_t       ev_rdata
);
  import coh_pkg::*;

  logic     req_win;
  logic     resp_win;
  logic     cpu_win;
  set_idx_t cpu_index;

  // Request bus first, then response bus, then the CPU
  assign req_win  = req_msg_valid;
  assign resp_win = resp_msg_valid & ~req_msg_valid;
  assign cpu_win  = (cache_read_request | dfp_read) & ~req_msg_valid & ~resp_msg_valid;

  assign cpu_index = dfp_addr[$bits(set_idx_t)-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ev_req       <= 1'b0;
      ev_resp      <= 1'b0;
      ev_cpu       <= 1'b0;
      ev_load_miss <= 1'b0;
      ev_load_hit  <= 1'b0;
      ev_inval     <= 1'b0;
    end else begin
      ev_req       <= req_win;
      ev_resp      <= resp_win;
      ev_cpu       <= cpu_win;
      ev_load_miss <= cpu_win & dfp_read & (|evict_candidate);
      ev_load_hit  <= cpu_win & cache_read_request & (|cache_hit_vector);
      ev_inval     <= invalidate_req;
    end
  end

  always_ff @(posedge clk) begin
    // Own test follows whichever bus message won
    ev_own   <= req_win ? (req_msg_source == node_id) : (resp_msg_source == node_id);
    ev_to_me <= (resp_msg_destination == node_id);
    if (req_win) begin
      ev_index <= req_msg_addr[$bits(set_idx_t)-1:0];
      ev_addr  <= req_msg_addr;
    end else if (resp_win) begin
      ev_index <= resp_msg_addr[$bits(set_idx_t)-1:0];
      ev_addr  <= resp_msg_addr;
    end else begin
      ev_index <= cpu_index;
      ev_addr  <= dfp_addr;
    end
    ev_req_kind    <= req_msg_kind;
    ev_source      <= req_msg_source;
    ev_resp_kind   <= resp_msg_kind;
    ev_resp_way    <= resp_msg_way;
    ev_data        <= resp_msg_data;
    ev_hit         <= cache_hit_vector;
    ev_victim      <= evict_candidate;
    ev_snoop_hit   <= bus_hit_vector;
    // Back invalidation runs beside the winning event
    ev_inval_index <= cpu_index;
    ev_inval_hit   <= cache_hit_vector;
    ev_rdata       <= bus_rdata;
  end

endmodule

// File: logic/coh_state_table.sv
`timescale 1ns/1ps

`include "coh_defines.svh"

module coh_state_table (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ev_req,
  input  logic                 ev_resp,
  input  logic                 ev_cpu,
  input  logic                 ev_own,
  input  coh_pkg::set_idx_t    ev_index,
  input  coh_pkg::addr_t       ev_addr,
  input  coh_pkg::bus_req_t    ev_req_kind,
  input  coh_pkg::node_id_t    ev_source,
  input  coh_pkg::resp_kind_t  ev_resp_kind,
  input  coh_pkg::way_idx_t    ev_resp_way,
  input  logic                 ev_to_me,
  input  coh_pkg::line_t       ev_data,
  input  coh_pkg::way_vec_t    ev_hit,
  input  coh_pkg::way_vec_t    ev_victim,
  input  coh_pkg::way_vec_t    ev_snoop_hit,
  input  logic                 ev_load_miss,
  input  logic                 ev_load_hit,
  input  logic                 ev_inval,
  input  coh_pkg::set_idx_t    ev_inval_index,
  input  coh_pkg::way_vec_t    ev_inval_hit,
  input  coh_pkg::line_t       ev_rdata,
  output logic                 act_issue_gets,
  output logic                 act_own_gets_seen,
  output logic                 act_fill,
  output logic                 act_hit,
  output logic                 act_supply,
  output logic                 act_supply_to_mem,
  output logic                 act_supply_done,
  output logic                 act_inval_done,
  output coh_pkg::way_idx_t    act_way,
  output coh_pkg::addr_t       act_addr,
  output coh_pkg::node_id_t    act_dest,
  output coh_pkg::line_t       act_data
);
  import coh_pkg::*;

  line_state_t state_q [`COH_WAYS][`COH_SETS];
  line_state_t cur     [`COH_WAYS];
  line_state_t nxt     [`COH_WAYS];

  logic     issue_gets_d;
  logic     own_gets_seen_d;
  logic     fill_d;
  logic     hit_d;
  logic     supply_d;
  logic     supply_to_mem_d;
  logic     supply_done_d;
  logic     inval_done_d;
  way_idx_t way_d;

  always_comb begin
    issue_gets_d    = 1'b0;
    own_gets_seen_d = 1'b0;
    fill_d          = 1'b0;
    hit_d           = 1'b0;
    supply_d        = 1'b0;
    supply_to_mem_d = 1'b0;
    supply_done_d   = 1'b0;
    inval_done_d    = ev_inval & (|ev_inval_hit);
    way_d           = '0;
    for (int i = 0; i < `COH_WAYS; i++) begin
      cur[i] = state_q[i][ev_index];
      nxt[i] = cur[i];
      if (ev_req) begin
        case (cur[i])
          LS_ISAD: begin
            if (ev_req_kind == REQ_GETS && ev_own && ev_victim[i]) begin
              nxt[i]          = LS_ISD;
              own_gets_seen_d = 1'b1;
            end
          end
          LS_S: begin
            if (ev_req_kind == REQ_GETM && !ev_own && ev_snoop_hit[i]) begin
              nxt[i] = LS_I;
            end
          end
          LS_E: begin
            // Another cache wants the line and we hold the only copy
            if (!ev_own && ev_snoop_hit[i] && ev_req_kind != REQ_NONE) begin
              nxt[i]          = (ev_req_kind == REQ_GETS) ? LS_SRD : LS_IRD;
              supply_d        = 1'b1;
              supply_to_mem_d = (ev_req_kind == REQ_GETS);
              way_d           = way_idx_t'(i);
            end
          end
          default: begin
          end
        endcase
      end else if (ev_resp) begin
        case (cur[i])
          LS_ISD: begin
            if (ev_to_me && ev_victim[i]) begin
              nxt[i] = (ev_resp_kind == RESP_EXCLUSIVE) ? LS_E : LS_S;
              fill_d = 1'b1;
              way_d  = way_idx_t'(i);
            end
          end
          LS_SRD, LS_IRD: begin
            // Our own data went out on the response bus
            if (ev_own && ev_resp_way == way_idx_t'(i)) begin
              nxt[i]        = (cur[i] == LS_SRD) ? LS_S : LS_I;
              supply_done_d = 1'b1;
            end
          end
          default: begin
          end
        endcase
      end else if (ev_cpu) begin
        case (cur[i])
          LS_I: begin
            if (ev_load_miss && ev_victim[i]) begin
              nxt[i]       = LS_ISAD;
              issue_gets_d = 1'b1;
            end
          end
          LS_S, LS_E: begin
            if (ev_load_hit && ev_hit[i]) begin
              hit_d = 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `COH_WAYS; w++) begin
        for (int s = 0; s < `COH_SETS; s++) begin
          state_q[w][s] <= LS_I;
        end
      end
    end else begin
      for (int w = 0; w < `COH_WAYS; w++) begin
        if (ev_req || ev_resp || ev_cpu) begin
          state_q[w][ev_index] <= nxt[w];
        end
        // Back invalidation lands last and wins on the same line
        if (ev_inval && ev_inval_hit[w]) begin
          state_q[w][ev_inval_index] <= LS_I;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_issue_gets    <= 1'b0;
      act_own_gets_seen <= 1'b0;
      act_fill          <= 1'b0;
      act_hit           <= 1'b0;
      act_supply        <= 1'b0;
      act_supply_to_mem <= 1'b0;
      act_supply_done   <= 1'b0;
      act_inval_done    <= 1'b0;
    end else begin
      act_issue_gets    <= issue_gets_d;
      act_own_gets_seen <= own_gets_seen_d;
      act_fill          <= fill_d;
      act_hit           <= hit_d;
      act_supply        <= supply_d;
      act_supply_to_mem <= supply_to_mem_d;
      act_supply_done   <= supply_done_d;
      act_inval_done    <= inval_done_d;
    end
  end

  always_ff @(posedge clk) begin
    act_way  <= way_d;
    act_addr <= ev_addr;
    act_dest <= ev_source;
    // Fill data comes from the response bus and supplied data from our array
    act_data <= ev_resp ? ev_data : ev_rdata;
  end

endmodule

// File: logic/coh_bus_issue.sv
`timescale 1ns/1ps

module coh_bus_issue (
  input  logic                clk,
  input  logic                rst,
  input  logic                act_issue_gets,
  input  logic                act_own_gets_seen,
  input  logic                act_fill,
  input  logic                act_hit,
  input  logic                act_supply,
  input  logic                act_supply_to_mem,
  input  logic                act_supply_done,
  input  logic                act_inval_done,
  input  coh_pkg::way_idx_t   act_way,
  input  coh_pkg::addr_t      act_addr,
  input  coh_pkg::node_id_t   act_dest,
  input  coh_pkg::line_t      act_data,
  output logic                req_bus_req,
  output coh_pkg::bus_req_t   req_tx_kind,
  output coh_pkg::addr_t      req_tx_addr,
  output logic                req_bus_busy,
  output logic                resp_bus_req,
  output coh_pkg::way_idx_t   resp_tx_way,
  output coh_pkg::node_id_t   resp_tx_destination,
  output logic                resp_tx_memory_flag,
  output coh_pkg::addr_t      resp_tx_addr,
  output coh_pkg::line_t      resp_tx_data,
  output coh_pkg::line_t      dfp_rdata,
  output logic                dfp_resp,
  output logic                invalidate_resp
);
  import coh_pkg::*;

  // Two reasons to hold the bus busy
  logic busy_fill;
  logic busy_supply;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_bus_req     <= 1'b0;
      req_tx_kind     <= REQ_NONE;
      resp_bus_req    <= 1'b0;
      busy_fill       <= 1'b0;
      busy_supply     <= 1'b0;
      dfp_resp        <= 1'b0;
      invalidate_resp <= 1'b0;
    end else begin
      // GetS request held until we see it on the request bus
      if (act_issue_gets) begin
        req_bus_req <= 1'b1;
        req_tx_kind <= REQ_GETS;
      end else if (act_own_gets_seen) begin
        req_bus_req <= 1'b0;
        req_tx_kind <= REQ_NONE;
      end

      // Waiting for the fill after our GetS went out
      if (act_own_gets_seen) begin
        busy_fill <= 1'b1;
      end else if (act_fill) begin
        busy_fill <= 1'b0;
      end

      // Data owed to another cache
      if (act_supply) begin
        busy_supply  <= 1'b1;
        resp_bus_req <= 1'b1;
      end else if (act_supply_done) begin
        busy_supply  <= 1'b0;
        resp_bus_req <= 1'b0;
      end

      dfp_resp        <= act_fill | act_hit;
      invalidate_resp <= act_inval_done;
    end
  end

  always_ff @(posedge clk) begin
    if (act_issue_gets) begin
      req_tx_addr <= act_addr;
    end
    if (act_supply) begin
      resp_tx_way         <= act_way;
      resp_tx_destination <= act_dest;
      resp_tx_memory_flag <= act_supply_to_mem;
      resp_tx_addr        <= act_addr;
      resp_tx_data        <= act_data;
    end
    if (act_fill) begin
      dfp_rdata <= act_data;
    end
  end

  assign req_bus_busy = busy_fill | busy_supply;

endmodule

// File: logic/icache_coherence.sv
`timescale 1ns/1ps

module icache_coherence #(
  parameter coh_pkg::node_id_t node_id = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  // CPU side
  input  coh_pkg::addr_t       dfp_addr,
  input  logic                 dfp_read,
  input  logic                 cache_read_request,
  output coh_pkg::line_t       dfp_rdata,
  output logic                 dfp_resp,
  // Tag array lookups
  input  coh_pkg::way_vec_t    cache_hit_vector,
  input  coh_pkg::way_vec_t    evict_candidate,
  input  coh_pkg::way_vec_t    bus_hit_vector,
  input  coh_pkg::line_t       bus_rdata,
  // Request bus
  input  logic                 req_msg_valid,
  input  coh_pkg::bus_req_t    req_msg_kind,
  input  coh_pkg::node_id_t    req_msg_source,
  input  coh_pkg::addr_t       req_msg_addr,
  output logic                 req_bus_req,
  output coh_pkg::bus_req_t    req_tx_kind,
  output coh_pkg::addr_t       req_tx_addr,
  output logic                 req_bus_busy,
  // Response bus
  input  logic                 resp_msg_valid,
  input  coh_pkg::resp_kind_t  resp_msg_kind,
  input  coh_pkg::node_id_t    resp_msg_source,
  input  coh_pkg::way_idx_t    resp_msg_way,
  input  coh_pkg::node_id_t    resp_msg_destination,
  input  coh_pkg::addr_t       resp_msg_addr,
  input  coh_pkg::line_t       resp_msg_data,
  output logic                 resp_bus_req,
  output coh_pkg::way_idx_t    resp_tx_way,
  output coh_pkg::node_id_t    resp_tx_destination,
  output logic                 resp_tx_memory_flag,
  output coh_pkg::addr_t       resp_tx_addr,
  output coh_pkg::line_t       resp_tx_data,
  // Inclusive policy
  input  logic                 invalidate_req,
  output logic                 invalidate_resp
);
  import coh_pkg::*;

  // Stage 1 to stage 2
  logic        ev_req, ev_resp, ev_cpu, ev_own, ev_to_me;
  logic        ev_load_miss, ev_load_hit, ev_inval;
  set_idx_t    ev_index, ev_inval_index;
  addr_t       ev_addr;
  bus_req_t    ev_req_kind;
  node_id_t    ev_source;
  resp_kind_t  ev_resp_kind;
  way_idx_t    ev_resp_way;
  line_t       ev_data, ev_rdata;
  way_vec_t    ev_hit, ev_victim, ev_snoop_hit, ev_inval_hit;

  // Stage 2 to stage 3
  logic        act_issue_gets, act_own_gets_seen, act_fill, act_hit;
  logic        act_supply, act_supply_to_mem, act_supply_done, act_inval_done;
  way_idx_t    act_way;
  addr_t       act_addr;
  node_id_t    act_dest;
  line_t       act_data;

  coh_event_decode #(.node_id(node_id)) u_decode (.*);

  coh_state_table u_state (.*);

  coh_bus_issue u_issue (.*);

endmodule

// File: tests/coh_assertions.sv
`timescale 1ns/1ps

module coh_assertions #(
  parameter coh_pkg::node_id_t node_id = '0
) (
  input logic                 clk,
  input logic                 rst,
  input coh_pkg::addr_t       dfp_addr,
  input logic                 dfp_read,
  input logic                 cache_read_request,
  input coh_pkg::line_t       dfp_rdata,
  input logic                 dfp_resp,
  input coh_pkg::way_vec_t    cache_hit_vector,
  input coh_pkg::way_vec_t    evict_candidate,
  input coh_pkg::way_vec_t    bus_hit_vector,
  input coh_pkg::line_t       bus_rdata,
  input logic                 req_msg_valid,
  input coh_pkg::bus_req_t    req_msg_kind,
  input coh_pkg::node_id_t    req_msg_source,
  input coh_pkg::addr_t       req_msg_addr,
  input logic                 req_bus_req,
  input coh_pkg::bus_req_t    req_tx_kind,
  input coh_pkg::addr_t       req_tx_addr,
  input logic                 req_bus_busy,
  input logic                 resp_msg_valid,
  input coh_pkg::node_id_t    resp_msg_source,
  input coh_pkg::node_id_t    resp_msg_destination,
  input coh_pkg::line_t       resp_msg_data,
  input logic                 resp_bus_req,
  input coh_pkg::way_idx_t    resp_tx_way,
  input coh_pkg::node_id_t    resp_tx_destination,
  input logic                 resp_tx_memory_flag,
  input coh_pkg::addr_t       resp_tx_addr,
  input coh_pkg::line_t       resp_tx_data,
  input logic                 invalidate_req,
  input logic                 invalidate_resp
);
  import coh_pkg::*;

  int fail_count = 0;

  logic cpu_ev;
  logic load_miss;
  logic load_hit;
  logic own_gets;
  logic snoop_other;
  logic fill_to_me;
  logic own_resp;
  logic inval_hit;

  // CPU only wins when both buses are idle
  assign cpu_ev      = (cache_read_request | dfp_read) & ~req_msg_valid & ~resp_msg_valid;
  assign load_miss   = cpu_ev & dfp_read & (|evict_candidate);
  assign load_hit    = cpu_ev & cache_read_request & (|cache_hit_vector);
  assign own_gets    = req_msg_valid && req_msg_kind == REQ_GETS && req_msg_source == node_id;
  assign snoop_other = req_msg_valid && req_msg_kind != REQ_NONE && req_msg_source != node_id
                       && (|bus_hit_vector);
  assign fill_to_me  = resp_msg_valid && !req_msg_valid && resp_msg_destination == node_id;
  assign own_resp    = resp_msg_valid && !req_msg_valid && resp_msg_source == node_id;
  assign inval_hit   = invalidate_req && (|cache_hit_vector);

  a_quiet_after_reset: assert property (@(posedge clk)
    rst |=> !req_bus_req && !resp_bus_req && !req_bus_busy && !dfp_resp && !invalidate_resp)
    else begin
      $error("Handshake output active after a reset cycle at %0t", $time);
      fail_count++;
    end

  a_gets_issue: assert property (@(posedge clk) disable iff (rst)
    $rose(req_bus_req) |-> $past(load_miss, 3) && req_tx_kind == REQ_GETS
                           && req_tx_addr == $past(dfp_addr, 3))
    else begin
      $error("GetS at %0t not matching a load miss 3 cycles earlier", $time);
      fail_count++;
    end

  // Seeing our own GetS drops the request and starts the wait for data
  a_gets_seen: assert property (@(posedge clk) disable iff (rst)
    $fell(req_bus_req) |-> $past(own_gets, 3) && req_bus_busy)
    else begin
      $error("GetS request dropped at %0t without own GetS 3 cycles earlier", $time);
      fail_count++;
    end

  a_cpu_resp: assert property (@(posedge clk) disable iff (rst)
    dfp_resp |-> $past(fill_to_me || load_hit, 3))
    else begin
      $error("CPU response at %0t without fill or hit 3 cycles earlier", $time);
      fail_count++;
    end

  a_fill_data: assert property (@(posedge clk) disable iff (rst)
    dfp_resp && $past(fill_to_me, 3) |-> dfp_rdata == $past(resp_msg_data, 3) && !req_bus_busy)
    else begin
      $error("Fill data or busy wrong at %0t", $time);
      fail_count++;
    end

  // A GetS leaves us in S so memory takes a copy of the data too
  a_supply_msg: assert property (@(posedge clk) disable iff (rst)
    $rose(resp_bus_req) |-> $past(snoop_other, 3) && req_bus_busy
      && resp_tx_destination == $past(req_msg_source, 3)
      && resp_tx_memory_flag == ($past(req_msg_kind, 3) == REQ_GETS)
      && resp_tx_addr == $past(req_msg_addr, 3)
      && (way_vec_t'(1) << resp_tx_way) == $past(bus_hit_vector, 3)
      && resp_tx_data == $past(bus_rdata, 3))
    else begin
      $error("Data supply message wrong at %0t", $time);
      fail_count++;
    end

  a_supply_done: assert property (@(posedge clk) disable iff (rst)
    $fell(resp_bus_req) |-> $past(own_resp, 3))
    else begin
      $error("Supply request dropped at %0t without own response 3 cycles earlier", $time);
      fail_count++;
    end

  a_inval_ack: assert property (@(posedge clk) disable iff (rst)
    invalidate_resp == $past(inval_hit, 3))
    else begin
      $error("Invalidation acknowledge at %0t not 3 cycles after a request", $time);
      fail_count++;
    end

endmodule

// File: tests/coh_tb.sv
`timescale 1ns/1ps

`include "coh_defines.svh"

module coh_tb;
  import coh_pkg::*;

  localparam int TIMEOUT   = 50;
  localparam int SIM_LIMIT = 100000;
  localparam int SIG_REQ   = 0;
  localparam int SIG_RESP  = 1;
  localparam int SIG_BUSY  = 2;
  localparam int SIG_DFP   = 3;
  localparam int SIG_INV   = 4;
  localparam node_id_t OWN = '0;
  localparam node_id_t MEM = node_id_t'(`COH_MEM_NODE);

  logic       clk;
  logic       rst;
  addr_t      dfp_addr;
  logic       dfp_read;
  logic       cache_read_request;
  line_t      dfp_rdata;
  logic       dfp_resp;
  way_vec_t   cache_hit_vector;
  way_vec_t   evict_candidate;
  way_vec_t   bus_hit_vector;
  line_t      bus_rdata;
  logic       req_msg_valid;
  bus_req_t   req_msg_kind;
  node_id_t   req_msg_source;
  addr_t      req_msg_addr;
  logic       req_bus_req;
  bus_req_t   req_tx_kind;
  addr_t      req_tx_addr;
  logic       req_bus_busy;
  logic       resp_msg_valid;
  resp_kind_t resp_msg_kind;
  node_id_t   resp_msg_source;
  way_idx_t   resp_msg_way;
  node_id_t   resp_msg_destination;
  addr_t      resp_msg_addr;
  line_t      resp_msg_data;
  logic       resp_bus_req;
  way_idx_t   resp_tx_way;
  node_id_t   resp_tx_destination;
  logic       resp_tx_memory_flag;
  addr_t      resp_tx_addr;
  line_t      resp_tx_data;
  logic       invalidate_req;
  logic       invalidate_resp;

  logic [31:0] lcg_state = 32'd76;
  int          tb_errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          mark;
  addr_t       a;
  way_idx_t    w;

  icache_coherence #(.node_id(OWN)) dut (.*);

  bind icache_coherence coh_assertions #(.node_id(node_id)) u_checks (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(SIM_LIMIT);
    $display("Simulation ran past its time limit without finishing");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int k = 0; k < 8; k++) begin
      l[k*32 +: 32] = next_rand();
    end
    return l;
  endfunction

  function automatic addr_t make_addr(input set_idx_t set);
    logic [31:0] r;
    r = next_rand();
    return {r[31:4], set};
  endfunction

  function automatic way_idx_t pick_way();
    logic [31:0] r;
    r = next_rand();
    return r[17:16];
  endfunction

  function automatic node_id_t pick_other();
    logic [31:0] r;
    r = next_rand();
    return r[9] ? node_id_t'(2) : node_id_t'(1);
  endfunction

  function automatic way_vec_t onehot(input way_idx_t way);
    return way_vec_t'(1) << way;
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SIG_REQ:  return req_bus_req;
      SIG_RESP: return resp_bus_req;
      SIG_BUSY: return req_bus_busy;
      SIG_DFP:  return dfp_resp;
      default:  return invalidate_resp;
    endcase
  endfunction

  function automatic int error_total();
    return tb_errors + dut.u_checks.fail_count;
  endfunction

  // Outputs change on the rising edge, so look at them on the falling one
  task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (probe(sel) !== level && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (probe(sel) !== level) begin
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
      tb_errors++;
    end
  endtask

  task automatic expect_no_dfp_resp(input string what);
    bit seen;
    seen = 1'b0;
    repeat (6) begin
      @(negedge clk);
      seen |= dfp_resp;
    end
    no_resp: assert (!seen) else begin
      $display("** Error at %0t: %s got a CPU response", $time, what);
      tb_errors++;
    end
  endtask

  task automatic cpu_read(input addr_t addr, input way_vec_t ways, input bit miss);
    @(posedge clk);
    dfp_addr           <= addr;
    dfp_read           <= miss;
    cache_read_request <= !miss;
    cache_hit_vector   <= miss ? '0 : ways;
    @(posedge clk);
    dfp_read           <= 1'b0;
    cache_read_request <= 1'b0;
    cache_hit_vector   <= '0;
  endtask

  task automatic req_bus_msg(input bus_req_t kind, input node_id_t src, input addr_t addr,
                             input way_vec_t snoop_hit);
    @(posedge clk);
    req_msg_valid  <= 1'b1;
    req_msg_kind   <= kind;
    req_msg_source <= src;
    req_msg_addr   <= addr;
    bus_hit_vector <= snoop_hit;
    bus_rdata      <= rand_line();
    @(posedge clk);
    req_msg_valid  <= 1'b0;
    bus_hit_vector <= '0;
  endtask

  task automatic resp_bus_msg(input resp_kind_t kind, input node_id_t src, input node_id_t dst,
                              input way_idx_t way, input addr_t addr);
    @(posedge clk);
    resp_msg_valid       <= 1'b1;
    resp_msg_kind        <= kind;
    resp_msg_source      <= src;
    resp_msg_destination <= dst;
    resp_msg_way         <= way;
    resp_msg_addr        <= addr;
    resp_msg_data        <= rand_line();
    @(posedge clk);
    resp_msg_valid       <= 1'b0;
  endtask

  // Victim way stays selected until the fill lands
  task automatic miss_fill(input addr_t addr, input way_idx_t way, input resp_kind_t kind);
    @(posedge clk);
    evict_candidate <= onehot(way);
    cpu_read(addr, '0, 1'b1);
    wait_level(SIG_REQ, 1'b1, "GetS request to rise");
    req_bus_msg(REQ_GETS, OWN, addr, '0);
    wait_level(SIG_REQ, 1'b0, "GetS request to drop");
    wait_level(SIG_BUSY, 1'b1, "bus busy after own GetS");
    resp_bus_msg(kind, MEM, OWN, way, addr);
    wait_level(SIG_DFP, 1'b1, "CPU response to the fill");
    wait_level(SIG_BUSY, 1'b0, "bus busy to clear after the fill");
  endtask

  task automatic snoop_supply(input addr_t addr, input way_idx_t way, input bus_req_t kind);
    node_id_t other;
    other = pick_other();
    req_bus_msg(kind, other, addr, onehot(way));
    wait_level(SIG_RESP, 1'b1, "data supply request to rise");
    resp_bus_msg(RESP_DATA, OWN, other, way, addr);
    wait_level(SIG_RESP, 1'b0, "data supply request to drop");
    wait_level(SIG_BUSY, 1'b0, "bus busy to clear after the supply");
  endtask

  task automatic back_invalidate(input addr_t addr, input way_idx_t way);
    @(posedge clk);
    invalidate_req   <= 1'b1;
    dfp_addr         <= addr;
    cache_hit_vector <= onehot(way);
    @(posedge clk);
    invalidate_req   <= 1'b0;
    cache_hit_vector <= '0;
  endtask

  task automatic close_test(input string name);
    if (error_total() != mark) begin
      failed++;
      $display("[%0t] %s: fail", $time, name);
    end else begin
      passed++;
      $display("[%0t] %s: ok", $time, name);
    end
  endtask

  initial begin
    rst                  = 1'b1;
    dfp_addr             = '0;
    dfp_read             = 1'b0;
    cache_read_request   = 1'b0;
    cache_hit_vector     = '0;
    evict_candidate      = '0;
    bus_hit_vector       = '0;
    bus_rdata            = '0;
    req_msg_valid        = 1'b0;
    req_msg_kind         = REQ_NONE;
    req_msg_source       = '0;
    req_msg_addr         = '0;
    resp_msg_valid       = 1'b0;
    resp_msg_kind        = RESP_DATA;
    resp_msg_source      = '0;
    resp_msg_way         = '0;
    resp_msg_destination = '0;
    resp_msg_addr        = '0;
    resp_msg_data        = '0;
    invalidate_req       = 1'b0;
    mark                 = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(negedge clk);
    close_test("reset");

    mark = error_total();
    a = make_addr(4'd1);
    w = pick_way();
    miss_fill(a, w, RESP_DATA);
    cpu_read(a, onehot(w), 1'b0);
    wait_level(SIG_DFP, 1'b1, "CPU response to a read hit");
    close_test("load miss and fill");

    mark = error_total();
    a = make_addr(4'd2);
    w = pick_way();
    miss_fill(a, w, RESP_EXCLUSIVE);
    snoop_supply(a, w, REQ_GETS);
    close_test("exclusive snoop by GetS");

    // Line ends in I, so a later read must stay unanswered
    mark = error_total();
    a = make_addr(4'd3);
    w = pick_way();
    miss_fill(a, w, RESP_EXCLUSIVE);
    snoop_supply(a, w, REQ_GETM);
    cpu_read(a, onehot(w), 1'b0);
    expect_no_dfp_resp("read after GetM snoop");
    close_test("exclusive snoop by GetM");

    mark = error_total();
    a = make_addr(4'd4);
    w = pick_way();
    miss_fill(a, w, RESP_DATA);
    back_invalidate(a, w);
    wait_level(SIG_INV, 1'b1, "invalidation acknowledge");
    cpu_read(a, onehot(w), 1'b0);
    expect_no_dfp_resp("read after back invalidation");
    close_test("back invalidation");

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, error_total());
    if (failed == 0 && error_total() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
logic/coh_pkg.sv
logic/coh_event_decode.sv
logic/coh_state_table.sv
logic/coh_bus_issue.sv
logic/icache_coherence.sv
tests/coh_assertions.sv
tests/coh_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= coh_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
